//--- hdl/ntrpt_pkg.sv
`default_nettype none

package ntrpt_pkg;

  //////////////////////////////////////////////////
  // Queue geometry
  //////////////////////////////////////////////////

  // Width of one stored interrupt word
  localparam int DATA_W = 32;

  // Number of slots in the shift register
  localparam int DEPTH = 16;

  // Count must reach DEPTH itself, so one extra state
  localparam int CNT_W = $clog2(DEPTH + 1);

  //////////////////////////////////////////////////
  // Cause encoding
  //////////////////////////////////////////////////

  // Low half of each word holds the cause code
  localparam int CAUSE_W = 16;

  // Machine-timer interrupt cause
  localparam logic [CAUSE_W-1:0] MTIP_CAUSE = 16'h0080;

  // One stored word, read whole by the head path
  // and split into fields by the cause comparator
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [DATA_W-CAUSE_W-1:0] info;
      logic [CAUSE_W-1:0]        cause;
    } fields;
  } entry_t;

  // Occupancy, 0 up to DEPTH
  typedef logic [CNT_W-1:0] count_t;

endpackage

`default_nettype wire

//--- hdl/fifo_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_ctrl_if;
  import ntrpt_pkg::*;

  // Strobes already filtered by the acceptance rule
  logic   push_acc;
  logic   pop_acc;

  // Registered occupancy, value before the coming edge
  count_t count;

  // Incoming word, written to slot 0 on push_acc
  entry_t wr_data;

  modport ctrl (
    output push_acc,
    output pop_acc,
    output count,
    output wr_data
  );

  modport store (
    input push_acc,
    input pop_acc,
    input count,
    input wr_data
  );

endinterface

`default_nettype wire

//--- hdl/fifo_occupancy.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_occupancy (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  logic                         pop,
  input  logic [ntrpt_pkg::DATA_W-1:0] din,
  fifo_ctrl_if.ctrl                    ctl,
  output logic                         pndng,
  output logic                         full
);
  import ntrpt_pkg::*;

  count_t cnt_q;
  count_t cnt_d;
  logic   push_ok;
  logic   pop_ok;

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////

  // Pop needs something stored; push needs room,
  // or a slot being freed by a pop in the same cycle
  assign pop_ok  = pop && (cnt_q != '0);
  assign push_ok = push && ((cnt_q < count_t'(DEPTH)) || pop_ok);

  always_comb begin
    cnt_d = cnt_q;
    if (push_ok && !pop_ok) begin
      cnt_d = cnt_q + 1'b1;
    end else if (pop_ok && !push_ok) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Towards the storage stage
  assign ctl.push_acc = push_ok;
  assign ctl.pop_acc  = pop_ok;
  assign ctl.count    = cnt_q;
  assign ctl.wr_data  = entry_t'(din);

  // Status straight from the current count
  assign pndng = (cnt_q != '0);
  assign full  = (cnt_q == count_t'(DEPTH));

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    cnt_q <= count_t'(DEPTH))
    else $error("occupancy count %0d above depth", cnt_q);

endmodule

`default_nettype wire

//--- hdl/shift_store.sv
`timescale 1ns/1ps
`default_nettype none

module shift_store (
  input  logic                        clk,
  input  logic                        reset,
  fifo_ctrl_if.store                  ctl,
  output ntrpt_pkg::entry_t           entries [ntrpt_pkg::DEPTH],
  output logic [ntrpt_pkg::DEPTH-1:0] valid
);
  import ntrpt_pkg::*;

  entry_t             nxt_entries [DEPTH];
  logic [DEPTH-1:0]   nxt_valid;

  //////////////////////////////////////////////////
  // Next state of the slots
  //////////////////////////////////////////////////

  always_comb begin
    nxt_entries = entries;
    nxt_valid   = valid;

    // Oldest word sits at count - 1; wipe it so a stale
    // cause cannot linger in the array
    if (ctl.pop_acc) begin
      for (int i = 0; i < DEPTH; i++) begin
        if (ctl.count == count_t'(i + 1)) begin
          nxt_entries[i] = '0;
          nxt_valid[i]   = 1'b0;
        end
      end
    end

    // Everything moves one slot older, new word enters at 0
    if (ctl.push_acc) begin
      for (int i = DEPTH - 1; i > 0; i--) begin
        nxt_entries[i] = nxt_entries[i-1];
        nxt_valid[i]   = nxt_valid[i-1];
      end
      nxt_entries[0] = ctl.wr_data;
      nxt_valid[0]   = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      entries <= '{default: '0};
      valid   <= '0;
    end else begin
      entries <= nxt_entries;
      valid   <= nxt_valid;
    end
  end

  // Stored words always form an unbroken run from slot 0
  a_valid_packed: assert property (@(posedge clk) disable iff (reset)
    (valid & (valid + DEPTH'(1))) == '0)
    else $error("valid mask %b has a hole", valid);

  // Slot mask and the occupancy counter never drift apart
  a_valid_count: assert property (@(posedge clk) disable iff (reset)
    $countones(valid) == int'(ctl.count))
    else $error("valid mask %b disagrees with count %0d", valid, ctl.count);

endmodule

`default_nettype wire

//--- hdl/read_select.sv
`timescale 1ns/1ps
`default_nettype none

module read_select (
  input  ntrpt_pkg::entry_t            entries [ntrpt_pkg::DEPTH],
  input  logic [ntrpt_pkg::DEPTH-1:0]  valid,
  output logic [ntrpt_pkg::DATA_W-1:0] dout
);
  import ntrpt_pkg::*;

  //////////////////////////////////////////////////
  // Head of queue
  //////////////////////////////////////////////////

  // Scan upwards so the highest valid slot is the
  // last one to write dout; that slot is the oldest.
  // Nothing stored gives an all-zero word
  always_comb begin
    dout = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (valid[i]) begin
        dout = entries[i].raw;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cause_scan.sv
`timescale 1ns/1ps
`default_nettype none

module cause_scan (
  input  ntrpt_pkg::entry_t           entries [ntrpt_pkg::DEPTH],
  input  logic [ntrpt_pkg::DEPTH-1:0] valid,
  output logic                        mtip
);
  import ntrpt_pkg::*;

  logic [DEPTH-1:0] hit;

  //////////////////////////////////////////////////
  // Timer cause match, one comparator per slot
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      // Only live slots may count as a match
      hit[i] = valid[i] && (entries[i].fields.cause == MTIP_CAUSE);
    end
  end

  // Level output, high while any stored word is a timer cause
  assign mtip = |hit;

endmodule

`default_nettype wire

//--- hdl/ntrpt_cam_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ntrpt_cam_fifo (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  logic                         pop,
  input  logic [ntrpt_pkg::DATA_W-1:0] din,
  output logic [ntrpt_pkg::DATA_W-1:0] dout,
  output logic                         pndng,
  output logic                         full,
  output logic                         mtip
);
  import ntrpt_pkg::*;

  // Control to storage
  fifo_ctrl_if ctl_if ();

  // Storage to the two observers
  entry_t           entries [DEPTH];
  logic [DEPTH-1:0] valid;

  fifo_occupancy i_occupancy (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .pop   (pop),
    .din   (din),
    .ctl   (ctl_if.ctrl),
    .pndng (pndng),
    .full  (full)
  );

  shift_store i_store (
    .clk     (clk),
    .reset   (reset),
    .ctl     (ctl_if.store),
    .entries (entries),
    .valid   (valid)
  );

  read_select i_read (
    .entries (entries),
    .valid   (valid),
    .dout    (dout)
  );

  cause_scan i_scan (
    .entries (entries),
    .valid   (valid),
    .mtip    (mtip)
  );

endmodule

`default_nettype wire

//--- verif/tb_ntrpt_cam_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ntrpt_cam_fifo;
  import ntrpt_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int SEED        = 76500;
  localparam int RAND_CYCLES = 2000;

  // Rough cycle budget of each test for the watchdog
  localparam int T_RESET = 8;
  localparam int T_ORDER = DEPTH + 4;
  localparam int T_FULL  = 2 * DEPTH + 6;
  localparam int T_BOTH  = 3 * DEPTH + 20;
  localparam int T_CAUSE = 30;
  localparam int T_RAND  = RAND_CYCLES + DEPTH + 4;
  localparam int MARGIN  = 200;
  localparam int RUN_CYCLES = T_RESET + T_ORDER + T_FULL + T_BOTH + T_CAUSE + T_RAND;

  logic              clk = 1'b0;
  logic              reset;
  logic              push;
  logic              pop;
  logic [DATA_W-1:0] din;
  logic [DATA_W-1:0] dout;
  logic              pndng;
  logic              full;
  logic              mtip;

  // Reference queue with the oldest word at index 0
  logic [DATA_W-1:0] model [$];
  logic              model_push_ok;
  logic              model_pop_ok;
  logic [DATA_W-1:0] exp_dout;
  logic              exp_pndng;
  logic              exp_full;
  logic              exp_mtip;

  string test_name;
  int    errors;
  int    test_errors_start;
  int    tests_run;
  int    cycles_checked;

  ntrpt_cam_fifo i_dut (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .pop   (pop),
    .din   (din),
    .dout  (dout),
    .pndng (pndng),
    .full  (full),
    .mtip  (mtip)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic model_has_timer();
    logic hit;
    hit = 1'b0;
    foreach (model[i]) begin
      if (model[i][CAUSE_W-1:0] == MTIP_CAUSE) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      model.delete();
    end else begin
      // Pop needs a stored word and push needs room or a pop in the same cycle
      model_pop_ok  = pop && (model.size() > 0);
      model_push_ok = push && ((model.size() < DEPTH) || model_pop_ok);
      if (model_pop_ok) begin
        void'(model.pop_front());
      end
      if (model_push_ok) begin
        model.push_back(din);
      end
    end
    exp_dout  = (model.size() > 0) ? model[0] : '0;
    exp_pndng = (model.size() > 0);
    exp_full  = (model.size() == DEPTH);
    exp_mtip  = model_has_timer();
  end

  //////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string sig, input logic [DATA_W-1:0] expected,
                                 input logic [DATA_W-1:0] actual);
    errors++;
    $display("ERR %s %s expected %h actual %h", test_name, sig, expected, actual);
  endtask

  a_dout: assert property (@(negedge clk) disable iff (reset) dout == exp_dout)
    else report_mismatch("dout", exp_dout, dout);

  a_pndng: assert property (@(negedge clk) disable iff (reset) pndng == exp_pndng)
    else report_mismatch("pndng", DATA_W'(exp_pndng), DATA_W'(pndng));

  a_full: assert property (@(negedge clk) disable iff (reset) full == exp_full)
    else report_mismatch("full", DATA_W'(exp_full), DATA_W'(full));

  a_mtip: assert property (@(negedge clk) disable iff (reset) mtip == exp_mtip)
    else report_mismatch("mtip", DATA_W'(exp_mtip), DATA_W'(mtip));

  always @(negedge clk) begin
    if (!reset) begin
      cycles_checked++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // One cycle of strobes set just after the rising edge
  task automatic drive(input logic p, input logic q, input logic [DATA_W-1:0] d);
    @(posedge clk);
    #2;
    push = p;
    pop  = q;
    din  = d;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 1'b0, '0);
  endtask

  task automatic pop_n(input int n);
    repeat (n) drive(1'b0, 1'b1, '0);
  endtask

  // Random word whose cause is anything but the timer code
  function automatic logic [DATA_W-1:0] other_word();
    logic [DATA_W-1:0] w;
    w = $urandom;
    if (w[CAUSE_W-1:0] == MTIP_CAUSE) begin
      w[0] = ~w[0];
    end
    return w;
  endfunction

  function automatic logic [DATA_W-1:0] timer_word();
    logic [DATA_W-1:0] w;
    w = $urandom;
    w[CAUSE_W-1:0] = MTIP_CAUSE;
    return w;
  endfunction

  task automatic push_n(input int n);
    repeat (n) drive(1'b1, 1'b0, other_word());
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_errors_start = errors;
  endtask

  task automatic finish_test();
    idle(1);
    // Last strobes of the test are compared at this falling edge
    @(negedge clk);
    #1;
    tests_run++;
    $display("test %s finished with %0d errors", test_name, errors - test_errors_start);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    push  = 1'b0;
    pop   = 1'b0;
    din   = '0;
    errors         = 0;
    tests_run      = 0;
    cycles_checked = 0;
    test_name      = "reset";
    void'($urandom(SEED));

    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    start_test("reset_values");
    idle(2);
    finish_test();

    start_test("push_pop_order");
    push_n(DEPTH / 2);
    pop_n(DEPTH / 2);
    finish_test();

    start_test("full_and_empty");
    push_n(DEPTH);
    drive(1'b1, 1'b0, other_word());
    pop_n(DEPTH);
    pop_n(1);
    finish_test();

    start_test("push_and_pop");
    // Only the push lands on an empty queue
    drive(1'b1, 1'b1, other_word());
    pop_n(1);
    push_n(DEPTH / 2);
    repeat (4) drive(1'b1, 1'b1, other_word());
    push_n(DEPTH / 2);
    repeat (4) drive(1'b1, 1'b1, other_word());
    pop_n(DEPTH);
    finish_test();

    start_test("timer_cause");
    push_n(2);
    drive(1'b1, 1'b0, timer_word());
    push_n(1);
    pop_n(4);
    drive(1'b1, 1'b0, timer_word());
    push_n(1);
    drive(1'b1, 1'b0, timer_word());
    pop_n(3);
    finish_test();

    start_test("random_traffic");
    repeat (RAND_CYCLES) begin
      drive(1'($urandom), 1'($urandom),
            (($urandom % 8) == 0) ? timer_word() : other_word());
    end
    pop_n(DEPTH);
    finish_test();

    $display("%0d tests run, %0d cycles compared, %0d errors", tests_run, cycles_checked,
             errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
hdl/ntrpt_pkg.sv
hdl/fifo_ctrl_if.sv
hdl/fifo_occupancy.sv
hdl/shift_store.sv
hdl/read_select.sv
hdl/cause_scan.sv
hdl/ntrpt_cam_fifo.sv
verif/tb_ntrpt_cam_fifo.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_ntrpt_cam_fifo
FLIST = sim.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run check clean

all: check

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)

# The fail message in the log means failure; a missing pass
# message means the run stopped early
check: run
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ) $(LOG)
